//--- logic/axi_pkg.sv
// AXI read channel types
`include "ifu_macros.svh"

package axi_pkg;

  typedef enum logic [`IFU_BURST_W-1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_e;

  typedef enum logic [`IFU_RESP_W-1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // Read address channel payload
  typedef struct packed {
    logic [`IFU_ID_W-1:0]   id;
    logic [`IFU_ADDR_W-1:0] addr;
    logic [`IFU_LEN_W-1:0]  len;
    logic [`IFU_SIZE_W-1:0] size;
    burst_e                 burst;
  } ar_t;

endpackage

//--- logic/ifu.sv
// Instruction fetch unit
`timescale 1ns/1ps
`include "ifu_macros.svh"

module ifu (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   redirect_valid,
  input  logic [`IFU_ADDR_W-1:0] redirect_pc,
  input  logic                   inst_ready,
  output logic                   inst_valid,
  output riscv_pkg::fetch_t      inst,
  ifu_axi_if.master              bus
);

  logic [`IFU_ADDR_W-1:0] pc_q;
  logic [`IFU_ADDR_W-1:0] next_pc;
  logic                   out_valid_q;
  riscv_pkg::fetch_t      out_q;
  riscv_pkg::instr_u      word;
  logic                   hit;
  logic                   can_load;
  logic                   fetch_req;
  logic                   load;

  // Output slot is free or drains this cycle
  assign can_load  = !out_valid_q || inst_ready;
  assign fetch_req = can_load && !redirect_valid;
  assign load      = fetch_req && hit;

  ifu_line_fetch line_fetch_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .fetch_pc  (pc_q),
    .fetch_req (fetch_req),
    .hit       (hit),
    .word      (word),
    .bus       (bus)
  );

  ifu_predecode predecode_inst (
    .pc      (pc_q),
    .word    (word),
    .next_pc (next_pc)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q        <= `IFU_RESET_PC;
      out_valid_q <= 1'b0;
    end else if (redirect_valid) begin
      pc_q        <= redirect_pc;
      out_valid_q <= 1'b0;
    end else if (load) begin
      pc_q        <= next_pc;
      out_valid_q <= 1'b1;
    end else if (inst_ready) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_q.pc   <= pc_q;
      out_q.word <= word;
    end
  end

  assign inst_valid = out_valid_q;
  assign inst       = out_q;

  // Fetch stays on word boundaries
  a_pc_align: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid |-> inst.pc[1:0] == 2'b00);

endmodule

//--- logic/ifu_axi_if.sv
// IFU read bus interface
`timescale 1ns/1ps
`include "ifu_macros.svh"

interface ifu_axi_if;

  // Read address channel
  axi_pkg::ar_t ar;
  logic         arvalid;
  logic         arready;

  // Read data channel
  logic [`IFU_ID_W-1:0]   rid;
  logic [`IFU_DATA_W-1:0] rdata;
  axi_pkg::resp_e         rresp;
  logic                   rlast;
  logic                   rvalid;
  logic                   rready;

  modport master (
    output ar, arvalid, rready,
    input  arready, rid, rdata, rresp, rlast, rvalid
  );

  modport slave (
    input  ar, arvalid, rready,
    output arready, rid, rdata, rresp, rlast, rvalid
  );

endinterface

//--- logic/ifu_line_fetch.sv
// Single line instruction buffer
`timescale 1ns/1ps
`include "ifu_macros.svh"

module ifu_line_fetch (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`IFU_ADDR_W-1:0] fetch_pc,
  input  logic                   fetch_req,
  output logic                   hit,
  output riscv_pkg::instr_u      word,
  ifu_axi_if.master              bus
);

  localparam int WORD_LSB = $clog2(`IFU_DATA_W / 8);
  localparam int OFS_W    = $clog2(`IFU_LINE_WORDS * `IFU_DATA_W / 8);
  localparam int IDX_W    = $clog2(`IFU_LINE_WORDS);
  localparam int TAG_W    = `IFU_ADDR_W - OFS_W;

  localparam logic [`IFU_LEN_W-1:0]  AR_LEN  = `IFU_LEN_W'(`IFU_LINE_WORDS - 1);
  localparam logic [`IFU_SIZE_W-1:0] AR_SIZE = `IFU_SIZE_W'(WORD_LSB);

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    DATA
  } state_e;

  state_e                 state_q;
  logic [TAG_W-1:0]       tag_q;
  logic [TAG_W-1:0]       req_tag_q;
  logic                   valid_q;
  logic                   err_q;
  logic [IDX_W-1:0]       beat_q;
  logic [`IFU_DATA_W-1:0] line_q [`IFU_LINE_WORDS];
  logic                   beat;
  logic                   beat_err;

  assign hit  = valid_q && (tag_q == fetch_pc[`IFU_ADDR_W-1:OFS_W]);
  assign word = line_q[fetch_pc[OFS_W-1:WORD_LSB]];

  // Burst always covers the whole aligned line
  assign bus.ar.id    = '0;
  assign bus.ar.addr  = {req_tag_q, {OFS_W{1'b0}}};
  assign bus.ar.len   = AR_LEN;
  assign bus.ar.size  = AR_SIZE;
  assign bus.ar.burst = axi_pkg::INCR;
  assign bus.arvalid  = (state_q == ADDR);
  assign bus.rready   = (state_q == DATA);

  assign beat     = bus.rvalid && bus.rready;
  assign beat_err = (bus.rid != bus.ar.id) ||
                    (bus.rresp == axi_pkg::SLVERR) || (bus.rresp == axi_pkg::DECERR);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      valid_q <= 1'b0;
      err_q   <= 1'b0;
      beat_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (fetch_req && !hit) begin
            state_q <= ADDR;
            // Old contents get overwritten by the refill
            valid_q <= 1'b0;
          end
        end
        ADDR: begin
          if (bus.arready) begin
            state_q <= DATA;
            beat_q  <= '0;
            err_q   <= 1'b0;
          end
        end
        DATA: begin
          if (beat) begin
            beat_q <= beat_q + 1'b1;
            err_q  <= err_q | beat_err;
            if (bus.rlast) begin
              state_q <= IDLE;
              valid_q <= !(err_q | beat_err);
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && fetch_req && !hit) begin
      req_tag_q <= fetch_pc[`IFU_ADDR_W-1:OFS_W];
    end
    if (beat) begin
      line_q[beat_q] <= bus.rdata;
      if (bus.rlast) begin
        tag_q <= req_tag_q;
      end
    end
  end

  // Burst ends exactly on the last word of the line
  a_rlast_len: assert property (@(posedge clk) disable iff (!rst_n)
    beat |-> bus.rlast == (beat_q == IDX_W'(`IFU_LINE_WORDS - 1)));

  // No read data while no burst is outstanding
  a_r_in_data: assert property (@(posedge clk) disable iff (!rst_n)
    bus.rvalid |-> state_q == DATA);

endmodule

//--- logic/ifu_macros.svh
// IFU bus and fetch parameters
`ifndef IFU_MACROS_SVH
`define IFU_MACROS_SVH

// Address and data widths
`define IFU_ADDR_W 32
`define IFU_DATA_W 32

// Read channel field widths
`define IFU_ID_W 4
`define IFU_LEN_W 8
`define IFU_SIZE_W 3
`define IFU_BURST_W 2
`define IFU_RESP_W 2

// Words per line which is the burst length plus one
`define IFU_LINE_WORDS 4

`define IFU_RESET_PC 32'h0000_0100

`endif

//--- logic/ifu_predecode.sv
// Static next PC selection
`timescale 1ns/1ps
`include "ifu_macros.svh"

module ifu_predecode (
  input  logic [`IFU_ADDR_W-1:0] pc,
  input  riscv_pkg::instr_u      word,
  output logic [`IFU_ADDR_W-1:0] next_pc
);

  riscv_pkg::opcode_e     op_class;
  logic [`IFU_ADDR_W-1:0] j_imm;
  logic [`IFU_ADDR_W-1:0] b_imm;
  logic [`IFU_ADDR_W-1:0] pc_plus4;

  // Sign extended 21 bit J immediate
  assign j_imm = {{(`IFU_ADDR_W - 21){word.j_fmt.imm_20}},
                  word.j_fmt.imm_20,
                  word.j_fmt.imm_19_12,
                  word.j_fmt.imm_11,
                  word.j_fmt.imm_10_1,
                  1'b0};

  // Sign extended 13 bit B immediate
  assign b_imm = {{(`IFU_ADDR_W - 13){word.b_fmt.imm_12}},
                  word.b_fmt.imm_12,
                  word.b_fmt.imm_11,
                  word.b_fmt.imm_10_5,
                  word.b_fmt.imm_4_1,
                  1'b0};

  assign pc_plus4 = pc + `IFU_ADDR_W'(4);

  always_comb begin
    if (word.j_fmt.opcode == riscv_pkg::JAL) begin
      op_class = riscv_pkg::JAL;
    end else if (word.b_fmt.opcode == riscv_pkg::BRANCH) begin
      op_class = riscv_pkg::BRANCH;
    end else begin
      op_class = riscv_pkg::OTHER;
    end
  end

  always_comb begin
    case (op_class)
      riscv_pkg::JAL: begin
        next_pc = pc + j_imm;
      end
      riscv_pkg::BRANCH: begin
        // Only backward branches are taken
        next_pc = word.b_fmt.imm_12 ? pc + b_imm : pc_plus4;
      end
      default: begin
        next_pc = pc_plus4;
      end
    endcase
  end

endmodule

//--- logic/ifu_wrap.sv
// IFU top level with flat bus ports
`timescale 1ns/1ps
`include "ifu_macros.svh"

module ifu_wrap (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   redirect_valid,
  input  logic [`IFU_ADDR_W-1:0] redirect_pc,
  input  logic                   inst_ready,
  output logic                   inst_valid,
  output logic [`IFU_ADDR_W-1:0] inst_pc,
  output logic [`IFU_DATA_W-1:0] inst_word,

  // AR channel
  output logic [`IFU_ID_W-1:0]    ifu_axi_arid,
  output logic [`IFU_ADDR_W-1:0]  ifu_axi_araddr,
  output logic [`IFU_LEN_W-1:0]   ifu_axi_arlen,
  output logic [`IFU_SIZE_W-1:0]  ifu_axi_arsize,
  output logic [`IFU_BURST_W-1:0] ifu_axi_arburst,
  output logic                    ifu_axi_arvalid,
  input  logic                    ifu_axi_arready,

  // R channel
  input  logic [`IFU_ID_W-1:0]   ifu_axi_rid,
  input  logic [`IFU_DATA_W-1:0] ifu_axi_rdata,
  input  logic [`IFU_RESP_W-1:0] ifu_axi_rresp,
  input  logic                   ifu_axi_rlast,
  input  logic                   ifu_axi_rvalid,
  output logic                   ifu_axi_rready
);

  riscv_pkg::fetch_t inst;

  ifu_axi_if ifu_axi_bus ();

  assign ifu_axi_arid    = ifu_axi_bus.ar.id;
  assign ifu_axi_araddr  = ifu_axi_bus.ar.addr;
  assign ifu_axi_arlen   = ifu_axi_bus.ar.len;
  assign ifu_axi_arsize  = ifu_axi_bus.ar.size;
  assign ifu_axi_arburst = ifu_axi_bus.ar.burst;
  assign ifu_axi_arvalid = ifu_axi_bus.arvalid;
  assign ifu_axi_bus.arready = ifu_axi_arready;

  assign ifu_axi_bus.rid    = ifu_axi_rid;
  assign ifu_axi_bus.rdata  = ifu_axi_rdata;
  assign ifu_axi_bus.rresp  = axi_pkg::resp_e'(ifu_axi_rresp);
  assign ifu_axi_bus.rlast  = ifu_axi_rlast;
  assign ifu_axi_bus.rvalid = ifu_axi_rvalid;
  assign ifu_axi_rready     = ifu_axi_bus.rready;

  ifu ifu_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .inst_ready     (inst_ready),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .bus            (ifu_axi_bus)
  );

  assign inst_pc   = inst.pc;
  assign inst_word = inst.word;

endmodule

//--- logic/riscv_pkg.sv
// RISC-V instruction types
`include "ifu_macros.svh"

package riscv_pkg;

  // Major opcodes that steer the fetch PC
  typedef enum logic [6:0] {
    JAL    = 7'b1101111,
    BRANCH = 7'b1100011,
    // Stand-in for every opcode that falls through
    OTHER  = 7'b0010011
  } opcode_e;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  // Same word seen as a jump or as a branch
  typedef union packed {
    j_fmt_t j_fmt;
    b_fmt_t b_fmt;
  } instr_u;

  // PC and word handed to decode
  typedef struct packed {
    logic [`IFU_ADDR_W-1:0] pc;
    instr_u                 word;
  } fetch_t;

endpackage

//--- run.sh
#!/bin/sh
# Build and run the IFU testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_ifu_wrap -o sim_ifu \
  && ./obj_dir/sim_ifu > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
if grep -q "sim failed" sim.log; then
  exit 1
fi
grep -q "sim passed" sim.log || exit 1
exit 0

//--- tests/prog_image.svh
// Test program image

function automatic riscv_pkg::instr_u jal_word(input int off);
  logic [20:0]       imm;
  riscv_pkg::instr_u ins;
  imm = off[20:0];
  ins.j_fmt.imm_20    = imm[20];
  ins.j_fmt.imm_10_1  = imm[10:1];
  ins.j_fmt.imm_11    = imm[11];
  ins.j_fmt.imm_19_12 = imm[19:12];
  ins.j_fmt.rd        = 5'd1;
  ins.j_fmt.opcode    = riscv_pkg::JAL;
  return ins;
endfunction

function automatic riscv_pkg::instr_u branch_word(input int off);
  logic [12:0]       imm;
  riscv_pkg::instr_u ins;
  imm = off[12:0];
  ins.b_fmt.imm_12   = imm[12];
  ins.b_fmt.imm_10_5 = imm[10:5];
  ins.b_fmt.rs2      = 5'd3;
  ins.b_fmt.rs1      = 5'd2;
  ins.b_fmt.funct3   = 3'd1;
  ins.b_fmt.imm_4_1  = imm[4:1];
  ins.b_fmt.imm_11   = imm[11];
  ins.b_fmt.opcode   = riscv_pkg::BRANCH;
  return ins;
endfunction

// Pattern repeats every 32 words
// Word 4 jumps to 14, word 19 branches back to 10 and word 10 jumps to 24
function automatic logic [31:0] image_word(input logic [31:0] addr);
  logic [31:0]       w;
  riscv_pkg::instr_u ins;
  w = addr >> 2;
  case (w[4:0])
    5'd4:    ins = jal_word(40);
    5'd10:   ins = jal_word(56);
    5'd16:   ins = branch_word(8);
    5'd19:   ins = branch_word(-36);
    default: ins = {w[19:0] ^ addr[31:12], 5'd1, 7'(riscv_pkg::OTHER)};
  endcase
  return ins;
endfunction

//--- tests/axi_mem_slave.sv
// Behavioural read burst memory
`timescale 1ns/1ps
`include "ifu_macros.svh"

module axi_mem_slave (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`IFU_ID_W-1:0]    arid,
  input  logic [`IFU_ADDR_W-1:0]  araddr,
  input  logic [`IFU_LEN_W-1:0]   arlen,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [`IFU_ID_W-1:0]    rid,
  output logic [`IFU_DATA_W-1:0]  rdata,
  output logic [`IFU_RESP_W-1:0]  rresp,
  output logic                    rlast,
  output logic                    rvalid,
  input  logic                    rready
);

  `include "prog_image.svh"

  integer                 seed;
  logic                   busy;
  logic [`IFU_ADDR_W-1:0] base;
  logic [`IFU_LEN_W-1:0]  beat;
  logic [`IFU_LEN_W-1:0]  len_q;
  logic [`IFU_ID_W-1:0]   id_q;

  initial seed = 32'h5362;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rlast   <= 1'b0;
      rdata   <= '0;
      rid     <= '0;
      rresp   <= '0;
      busy    <= 1'b0;
      beat    <= '0;
    end else if (!busy) begin
      rvalid <= 1'b0;
      if (arvalid && arready) begin
        busy    <= 1'b1;
        base    <= araddr;
        len_q   <= arlen;
        id_q    <= arid;
        beat    <= '0;
        arready <= 1'b0;
      end else begin
        arready <= ($random(seed) & 3) != 0;
      end
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
      if (rlast) begin
        busy <= 1'b0;
      end else begin
        beat <= beat + 1'b1;
      end
    end else if (!rvalid && (($random(seed) & 3) != 0)) begin
      // Incrementing beat address
      rvalid <= 1'b1;
      rdata  <= image_word(base + {22'd0, beat, 2'b00});
      rlast  <= (beat == len_q);
      rid    <= id_q;
      rresp  <= '0;
    end
  end

endmodule

//--- tests/tb_ifu_wrap.sv
// IFU top level testbench
`timescale 1ns/1ps
`include "ifu_macros.svh"

module tb_ifu_wrap;

  `include "prog_image.svh"

  logic                    clk;
  logic                    rst_n;
  logic                    redirect_valid;
  logic [`IFU_ADDR_W-1:0]  redirect_pc;
  logic                    inst_ready;
  logic                    inst_valid;
  logic [`IFU_ADDR_W-1:0]  inst_pc;
  logic [`IFU_DATA_W-1:0]  inst_word;
  logic [`IFU_ID_W-1:0]    arid;
  logic [`IFU_ADDR_W-1:0]  araddr;
  logic [`IFU_LEN_W-1:0]   arlen;
  logic [`IFU_SIZE_W-1:0]  arsize;
  logic [`IFU_BURST_W-1:0] arburst;
  logic                    arvalid;
  logic                    arready;
  logic [`IFU_ID_W-1:0]    rid;
  logic [`IFU_DATA_W-1:0]  rdata;
  logic [`IFU_RESP_W-1:0]  rresp;
  logic                    rlast;
  logic                    rvalid;
  logic                    rready;

  integer                 seed;
  int                     errors;
  int                     timeouts;
  int                     xfer_count;
  logic [`IFU_ADDR_W-1:0] exp_pc;
  logic [`IFU_ADDR_W-1:0] last_ar;
  logic                   seen_ar;
  logic                   prev_stall;
  logic [`IFU_ADDR_W-1:0] prev_pc;
  logic [`IFU_DATA_W-1:0] prev_word;

  ifu_wrap dut0 (
    .clk (clk), .rst_n (rst_n),
    .redirect_valid (redirect_valid), .redirect_pc (redirect_pc),
    .inst_ready (inst_ready), .inst_valid (inst_valid),
    .inst_pc (inst_pc), .inst_word (inst_word),
    .ifu_axi_arid (arid), .ifu_axi_araddr (araddr), .ifu_axi_arlen (arlen),
    .ifu_axi_arsize (arsize), .ifu_axi_arburst (arburst),
    .ifu_axi_arvalid (arvalid), .ifu_axi_arready (arready),
    .ifu_axi_rid (rid), .ifu_axi_rdata (rdata), .ifu_axi_rresp (rresp),
    .ifu_axi_rlast (rlast), .ifu_axi_rvalid (rvalid), .ifu_axi_rready (rready)
  );

  axi_mem_slave mem0 (
    .clk (clk), .rst_n (rst_n),
    .arid (arid), .araddr (araddr), .arlen (arlen),
    .arvalid (arvalid), .arready (arready),
    .rid (rid), .rdata (rdata), .rresp (rresp),
    .rlast (rlast), .rvalid (rvalid), .rready (rready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  // JAL and backward branches taken, everything else falls through
  function automatic logic [31:0] ref_next_pc(input logic [31:0] pc, input logic [31:0] w);
    logic [31:0] j_off;
    logic [31:0] b_off;
    j_off = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    b_off = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    if (w[6:0] == 7'b1101111) begin
      return pc + j_off;
    end else if (w[6:0] == 7'b1100011 && w[31]) begin
      return pc + b_off;
    end
    return pc + 32'd4;
  endfunction

  // Compare process
  always @(posedge clk) begin
    if (rst_n) begin
      if (prev_stall && inst_valid) begin
        check("inst_pc held", inst_pc, prev_pc);
        check("inst_word held", inst_word, prev_word);
      end
      if (inst_valid && inst_ready) begin
        check("inst_pc", inst_pc, exp_pc);
        check("inst_word", inst_word, image_word(exp_pc));
        exp_pc = ref_next_pc(exp_pc, image_word(exp_pc));
        xfer_count++;
      end
      if (redirect_valid) begin
        exp_pc = redirect_pc;
      end
      if (arvalid && arready) begin
        check("ifu_axi_arid", 32'(arid), 32'd0);
        check("ifu_axi_arlen", 32'(arlen), 32'd3);
        check("ifu_axi_arsize", 32'(arsize), 32'd2);
        check("ifu_axi_arburst", 32'(arburst), 32'd1);
        check("ifu_axi_araddr low bits", 32'(araddr[3:0]), 32'd0);
        if (seen_ar && araddr == last_ar) begin
          errors++;
          $display("Line at %h was refilled without crossing a line boundary", araddr);
        end
        last_ar = araddr;
        seen_ar = 1'b1;
      end
      prev_stall = inst_valid && !inst_ready;
      prev_pc    = inst_pc;
      prev_word  = inst_word;
    end
  end

  task automatic wait_transfers(input int n, input int limit, input logic rand_ready);
    int target;
    int cycles;
    @(negedge clk);
    target = xfer_count + n;
    cycles = 0;
    while (xfer_count < target && cycles < limit) begin
      @(posedge clk);
      inst_ready <= rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
      cycles++;
      // Transfer count is settled half a cycle after the edge
      @(negedge clk);
    end
    if (xfer_count < target) begin
      timeouts++;
      $display("Timed out waiting for %0d decode transfers", n);
    end
  endtask

  task automatic pulse_redirect(input logic [31:0] pc);
    @(posedge clk);
    redirect_valid <= 1'b1;
    redirect_pc    <= pc;
    @(posedge clk);
    redirect_valid <= 1'b0;
  endtask

  task automatic wait_burst(input int limit);
    int cycles;
    cycles = 0;
    while (!rready && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (!rready) begin
      timeouts++;
      $display("Timed out waiting for a read burst to start");
    end
  endtask

  initial begin
    seed = 32'h5362;
    errors = 0;
    timeouts = 0;
    xfer_count = 0;
    exp_pc = `IFU_RESET_PC;
    seen_ar = 1'b0;
    prev_stall = 1'b0;
    rst_n = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc = '0;
    inst_ready = 1'b0;
    repeat (10) begin
      @(negedge clk);
      check("ifu_axi_arvalid", 32'(arvalid), 32'd0);
      check("ifu_axi_rready", 32'(rready), 32'd0);
      check("inst_valid", 32'(inst_valid), 32'd0);
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check("ifu_axi_arvalid", 32'(arvalid), 32'd0);
    check("ifu_axi_rready", 32'(rready), 32'd0);
    check("inst_valid", 32'(inst_valid), 32'd0);

    wait_transfers(60, 2000, 1'b0);
    wait_transfers(80, 4000, 1'b1);
    pulse_redirect(32'h0000_0400);
    wait_transfers(30, 2000, 1'b1);
    // Redirect while the refill is still running
    wait_burst(500);
    pulse_redirect(32'h0000_0530);
    wait_transfers(30, 2000, 1'b1);
    wait_transfers(20, 1000, 1'b0);

    $display("errors: %0d check failures, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+logic
+incdir+tests
logic/riscv_pkg.sv
logic/axi_pkg.sv
logic/ifu_axi_if.sv
logic/ifu_line_fetch.sv
logic/ifu_predecode.sv
logic/ifu.sv
logic/ifu_wrap.sv
tests/axi_mem_slave.sv
tests/tb_ifu_wrap.sv
